// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_axi_mem_slave
FLIST     = axi_mem_slave.f
LOG       = sim.log
SRCS      = $(shell grep -v '^+' $(FLIST))
BIN       = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: axi_mem_slave.f
logic/axi_mem_pkg.sv
logic/burst_addr_gen.sv
logic/mem_array.sv
logic/txn_control.sv
logic/axi_mem_slave.sv
tests/axi_mem_slave_properties.sv
tests/tb_axi_mem_slave.sv

// File: logic/axi_mem_pkg.sv
/*
  shared definitions for the memory-backed AXI slave
  - word address, data and burst length widths
  - memory depth
  - burst type and response codes
  - burst request struct for the aw and ar channels
*/

package axi_mem_pkg;

  // sizes
  localparam int addr_width = 4;
  localparam int data_width = 32;
  localparam int len_width  = 4;
  localparam int mem_depth  = 16;

  // ------------------------------
  // burst and response codes
  // ------------------------------
  typedef enum logic [1:0] {
    burst_fixed    = 2'b00,
    burst_incr     = 2'b01,
    burst_wrap     = 2'b10,
    burst_reserved = 2'b11
  } burst_t;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } resp_t;

  // one burst request of len+1 beats starting at addr
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [len_width-1:0]  len;
    burst_t                burst;
  } burst_req_t;

endpackage

// File: logic/axi_mem_slave.sv
/*
  top level of the memory-backed AXI slave
  - channel controller for write and read handshakes
  - write and read burst address generators
  - 16-word array with written flags
*/

`timescale 1ns/100ps

module axi_mem_slave import axi_mem_pkg::*; (
  input  logic                  aclk,
  input  logic                  aresetn,
  // write request, data and response
  input  burst_req_t            aw_req,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [data_width-1:0] wdata,
  input  logic                  wvalid,
  output logic                  wready,
  output resp_t                 bresp,
  output logic                  bvalid,
  input  logic                  bready,
  // read request and data
  input  burst_req_t            ar_req,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [data_width-1:0] rdata,
  output resp_t                 rresp,
  output logic                  rlast,
  output logic                  rvalid,
  input  logic                  rready
);

  logic                  w_start;
  logic                  w_step;
  logic                  w_last;
  logic                  w_legal;
  logic [addr_width-1:0] w_addr;
  logic                  r_start;
  logic                  r_step;
  logic                  r_last;
  logic                  r_legal;
  logic [addr_width-1:0] r_addr;
  logic                  we;
  logic                  rd_written;

  // ------------------------------
  // channel control
  // ------------------------------
  txn_control u_ctrl (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .awvalid    (awvalid),
    .wvalid     (wvalid),
    .bready     (bready),
    .arvalid    (arvalid),
    .rready     (rready),
    .w_last     (w_last),
    .w_legal    (w_legal),
    .r_last     (r_last),
    .r_legal    (r_legal),
    .rd_written (rd_written),
    .awready    (awready),
    .wready     (wready),
    .bvalid     (bvalid),
    .arready    (arready),
    .rvalid     (rvalid),
    .rlast      (rlast),
    .bresp      (bresp),
    .rresp      (rresp),
    .w_start    (w_start),
    .w_step     (w_step),
    .we         (we),
    .r_start    (r_start),
    .r_step     (r_step)
  );

  // ------------------------------
  // address sequencing
  // ------------------------------
  burst_addr_gen u_waddr (
    .aclk    (aclk),
    .aresetn (aresetn),
    .req     (aw_req),
    .start   (w_start),
    .step    (w_step),
    .addr    (w_addr),
    .last    (w_last),
    .legal   (w_legal)
  );

  burst_addr_gen u_raddr (
    .aclk    (aclk),
    .aresetn (aresetn),
    .req     (ar_req),
    .start   (r_start),
    .step    (r_step),
    .addr    (r_addr),
    .last    (r_last),
    .legal   (r_legal)
  );

  // storage with its read port driving rdata directly
  mem_array u_mem (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .we         (we),
    .wr_addr    (w_addr),
    .wr_data    (wdata),
    .rd_addr    (r_addr),
    .rd_data    (rdata),
    .rd_written (rd_written)
  );

endmodule

// File: logic/burst_addr_gen.sv
/*
  burst address sequencer
  - captures a request on start, advances one beat per step
  - fixed, incr and wrap addressing
  - last beat and burst legality flags
*/

`timescale 1ns/100ps

module burst_addr_gen import axi_mem_pkg::*; (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  burst_req_t            req,
  input  logic                  start,
  input  logic                  step,
  output logic [addr_width-1:0] addr,
  output logic                  last,
  output logic                  legal
);

  burst_t                burst_q;
  logic [len_width-1:0]  len_q;
  logic [len_width-1:0]  cnt_q;
  logic [addr_width-1:0] addr_q;
  logic [addr_width-1:0] addr_inc;
  logic [addr_width-1:0] wrap_mask;
  logic [addr_width-1:0] addr_next;

  // wrap block is len+1 words, so len itself is the offset mask
  assign wrap_mask = addr_width'(len_q);
  assign addr_inc  = addr_q + 1'b1;

  always_comb begin
    case (burst_q)
      burst_fixed: addr_next = addr_q;
      burst_wrap:  addr_next = (addr_q & ~wrap_mask) | (addr_inc & wrap_mask);
      default:     addr_next = addr_inc;
    endcase
  end

  always_comb begin
    case (burst_q)
      burst_reserved: legal = 1'b0;
      // wrap only on 2, 4, 8 or 16 beats
      burst_wrap:     legal = (len_q == 4'd1) || (len_q == 4'd3) ||
                              (len_q == 4'd7) || (len_q == 4'd15);
      default:        legal = 1'b1;
    endcase
  end

  assign addr = addr_q;
  assign last = (cnt_q == len_q);

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      burst_q <= burst_fixed;
      len_q   <= '0;
      cnt_q   <= '0;
      addr_q  <= '0;
    end else if (start) begin
      burst_q <= req.burst;
      len_q   <= req.len;
      cnt_q   <= '0;
      addr_q  <= req.addr;
    end else if (step) begin
      cnt_q  <= cnt_q + 1'b1;
      addr_q <= addr_next;
    end
  end

endmodule

// File: logic/mem_array.sv
/*
  word storage for the slave
  - mem_depth words with one written flag each
  - single write port, combinational read port
*/

`timescale 1ns/100ps

module mem_array import axi_mem_pkg::*; (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  we,
  input  logic [addr_width-1:0] wr_addr,
  input  logic [data_width-1:0] wr_data,
  input  logic [addr_width-1:0] rd_addr,
  output logic [data_width-1:0] rd_data,
  output logic                  rd_written
);

  logic [data_width-1:0] mem_q [mem_depth];
  logic [mem_depth-1:0]  written_q;

  // ------------------------------
  // write port
  // ------------------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      // words read back as zero until written
      for (int i = 0; i < mem_depth; i++) begin
        mem_q[i] <= '0;
      end
      written_q <= '0;
    end else if (we) begin
      mem_q[wr_addr]     <= wr_data;
      written_q[wr_addr] <= 1'b1;
    end
  end

  // ------------------------------
  // read port
  // ------------------------------
  assign rd_data    = mem_q[rd_addr];
  assign rd_written = written_q[rd_addr];

endmodule

// File: logic/txn_control.sv
/*
  write and read channel control
  - write FSM: idle, data, response
  - read FSM: idle, beat
  - start and step strobes for the address generators
  - response code selection
*/

`timescale 1ns/100ps

module txn_control import axi_mem_pkg::*; (
  input  logic  aclk,
  input  logic  aresetn,
  // handshakes from the master
  input  logic  awvalid,
  input  logic  wvalid,
  input  logic  bready,
  input  logic  arvalid,
  input  logic  rready,
  // status from generators and array
  input  logic  w_last,
  input  logic  w_legal,
  input  logic  r_last,
  input  logic  r_legal,
  input  logic  rd_written,
  // handshakes to the master
  output logic  awready,
  output logic  wready,
  output logic  bvalid,
  output logic  arready,
  output logic  rvalid,
  output logic  rlast,
  output resp_t bresp,
  output resp_t rresp,
  // strobes
  output logic  w_start,
  output logic  w_step,
  output logic  we,
  output logic  r_start,
  output logic  r_step
);

  typedef enum logic [1:0] {
    w_idle = 2'b00,
    w_data = 2'b01,
    w_resp = 2'b10
  } wstate_t;

  typedef enum logic {
    r_idle = 1'b0,
    r_beat = 1'b1
  } rstate_t;

  wstate_t wstate;
  rstate_t rstate;

  // ------------------------------
  // write channel
  // ------------------------------
  assign awready = (wstate == w_idle);
  assign wready  = (wstate == w_data);
  assign bvalid  = (wstate == w_resp);

  assign w_start = awvalid && awready;
  assign w_step  = wvalid && wready;
  // illegal bursts take all beats but store nothing
  assign we      = w_step && w_legal;

  assign bresp = w_legal ? resp_okay : resp_slverr;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wstate <= w_idle;
    end else begin
      case (wstate)
        w_idle: begin
          if (w_start) begin
            wstate <= w_data;
          end
        end
        w_data: begin
          // beat count comes from len, not from a last flag
          if (w_step && w_last) begin
            wstate <= w_resp;
          end
        end
        w_resp: begin
          if (bready) begin
            wstate <= w_idle;
          end
        end
        default: wstate <= w_idle;
      endcase
    end
  end

  // ------------------------------
  // read channel
  // ------------------------------
  assign arready = (rstate == r_idle);
  assign rvalid  = (rstate == r_beat);
  assign rlast   = rvalid && r_last;

  assign r_start = arvalid && arready;
  assign r_step  = rvalid && rready;

  // unwritten word or bad burst type gives slverr
  assign rresp = (r_legal && rd_written) ? resp_okay : resp_slverr;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      rstate <= r_idle;
    end else begin
      case (rstate)
        r_idle: begin
          if (r_start) begin
            rstate <= r_beat;
          end
        end
        r_beat: begin
          if (r_step && r_last) begin
            rstate <= r_idle;
          end
        end
        default: rstate <= r_idle;
      endcase
    end
  end

endmodule

// File: tests/axi_mem_slave_properties.sv
/*
  concurrent checks on the slave handshakes
  - write address and data phases exclusive
  - rlast only with rvalid
  - write response and read data held under back-pressure
*/

`timescale 1ns/100ps

module axi_mem_slave_properties import axi_mem_pkg::*; (
  input logic                  aclk,
  input logic                  aresetn,
  input logic                  awready,
  input logic                  wready,
  input logic                  bvalid,
  input logic                  bready,
  input logic                  rvalid,
  input logic                  rready,
  input logic                  rlast,
  input logic [data_width-1:0] rdata,
  input resp_t                 rresp
);

  a_aw_w_exclusive: assert property (@(posedge aclk) disable iff (!aresetn)
    !(awready && wready))
    else $error("awready and wready high together");

  a_rlast_with_rvalid: assert property (@(posedge aclk) disable iff (!aresetn)
    rlast |-> rvalid)
    else $error("rlast high without rvalid");

  // response must wait for bready
  a_bvalid_held: assert property (@(posedge aclk) disable iff (!aresetn)
    (bvalid && !bready) |=> bvalid)
    else $error("bvalid dropped before the b transfer");

  a_rdata_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    (rvalid && !rready) |=> ($stable(rdata) && $stable(rresp)))
    else $error("rdata or rresp changed while stalled");

endmodule

// File: tests/tb_axi_mem_slave.sv
/*
  testbench for the memory-backed AXI slave
  - clock, reset and falling-edge stimulus
  - directed and seeded random bursts with back-pressure gaps
  - reference model of words, written flags and burst addressing
*/

`timescale 1ns/100ps

module tb_axi_mem_slave import axi_mem_pkg::*; ();

  localparam int timeout_cycles = 100;

  logic                  aclk = 1'b0;
  logic                  aresetn;
  burst_req_t            aw_req;
  burst_req_t            ar_req;
  logic                  awvalid;
  logic                  wvalid;
  logic                  bready;
  logic                  arvalid;
  logic                  rready;
  logic [data_width-1:0] wdata;
  logic                  awready;
  logic                  wready;
  logic                  bvalid;
  logic                  arready;
  logic                  rvalid;
  logic                  rlast;
  resp_t                 bresp;
  resp_t                 rresp;
  logic [data_width-1:0] rdata;

  logic [data_width-1:0] model_mem [mem_depth];
  logic                  model_flag [mem_depth];
  integer                seed;
  int                    errors = 0;
  int                    bursts = 0;

  always #20 aclk = ~aclk;

  axi_mem_slave dut (.*);

  bind axi_mem_slave axi_mem_slave_properties u_props (
    .aclk    (aclk),
    .aresetn (aresetn),
    .awready (awready),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready),
    .rvalid  (rvalid),
    .rready  (rready),
    .rlast   (rlast),
    .rdata   (rdata),
    .rresp   (rresp)
  );

  // ------------------------------
  // reporting
  // ------------------------------
  task automatic note_failure(string msg);
    errors++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  task automatic abort_run(string what);
    $display("timeout at %0t: %s never came", $time, what);
    $display("bursts: %0d errors: %0d", bursts, errors + 1);
    $display("Verification failed");
    $finish;
  endtask

  // ------------------------------
  // burst rules for the model
  // ------------------------------
  function automatic bit is_legal(burst_req_t req);
    if (req.burst == burst_reserved) return 1'b0;
    if (req.burst == burst_wrap) return req.len inside {4'd1, 4'd3, 4'd7, 4'd15};
    return 1'b1;
  endfunction

  function automatic int next_addr(burst_req_t req, int a);
    int size;
    int base;
    size = int'(req.len) + 1;
    base = a - (a % size);
    if (req.burst == burst_fixed) return a;
    // wrap stays inside its aligned block of len+1 words
    if (req.burst == burst_wrap && is_legal(req)) return base + ((a - base + 1) % size);
    return (a + 1) % mem_depth;
  endfunction

  function automatic burst_req_t make_req(int addr, int len, burst_t burst);
    burst_req_t req;
    req.addr  = addr_width'(addr);
    req.len   = len_width'(len);
    req.burst = burst;
    return req;
  endfunction

  task automatic idle_gap();
    int gap;
    gap = $random(seed) & 3;
    repeat (gap) @(negedge aclk);
  endtask

  // ------------------------------
  // write burst with model update
  // ------------------------------
  task automatic write_burst(burst_req_t req);
    int n;
    int a;
    int beats;
    logic [data_width-1:0] d;
    resp_t exp_resp;
    beats = int'(req.len) + 1;
    a = int'(req.addr);
    exp_resp = is_legal(req) ? resp_okay : resp_slverr;
    bursts++;
    aw_req = req;
    awvalid = 1'b1;
    n = 0;
    while (!awready) begin
      @(negedge aclk);
      n++;
      if (n > timeout_cycles) abort_run("awready");
    end
    @(negedge aclk);
    awvalid = 1'b0;
    if (awready !== 1'b0 || wready !== 1'b1) note_failure("aw transfer did not open data phase");
    for (int i = 0; i < beats; i++) begin
      idle_gap();
      d = $random(seed);
      wdata = d;
      wvalid = 1'b1;
      n = 0;
      while (!wready) begin
        @(negedge aclk);
        n++;
        if (n > timeout_cycles) abort_run("wready");
      end
      @(negedge aclk);
      wvalid = 1'b0;
      if (is_legal(req)) begin
        model_mem[a] = d;
        model_flag[a] = 1'b1;
      end
      a = next_addr(req, a);
      if (i < beats - 1 && wready !== 1'b1)
        note_failure($sformatf("wready low after beat %0d", i));
    end
    if (wready !== 1'b0 || bvalid !== 1'b1) note_failure("bvalid not seen after last beat");
    idle_gap();
    bready = 1'b1;
    n = 0;
    while (!bvalid) begin
      @(negedge aclk);
      n++;
      if (n > timeout_cycles) abort_run("bvalid");
    end
    if (bresp !== exp_resp) note_failure($sformatf("bresp %0d, expected %0d", bresp, exp_resp));
    @(negedge aclk);
    bready = 1'b0;
    if (awready !== 1'b1 || bvalid !== 1'b0) note_failure("write channel not idle after b");
  endtask

  // ------------------------------
  // read burst checked against the model
  // ------------------------------
  task automatic read_burst(burst_req_t req);
    int n;
    int a;
    int beats;
    resp_t exp_resp;
    beats = int'(req.len) + 1;
    a = int'(req.addr);
    bursts++;
    ar_req = req;
    arvalid = 1'b1;
    n = 0;
    while (!arready) begin
      @(negedge aclk);
      n++;
      if (n > timeout_cycles) abort_run("arready");
    end
    @(negedge aclk);
    arvalid = 1'b0;
    if (arready !== 1'b0 || rvalid !== 1'b1) note_failure("ar transfer did not raise rvalid");
    for (int i = 0; i < beats; i++) begin
      rready = 1'b0;
      idle_gap();
      rready = 1'b1;
      n = 0;
      while (!rvalid) begin
        @(negedge aclk);
        n++;
        if (n > timeout_cycles) abort_run("rvalid");
      end
      exp_resp = (is_legal(req) && model_flag[a]) ? resp_okay : resp_slverr;
      if (rresp !== exp_resp)
        note_failure($sformatf("beat %0d rresp %0d, expected %0d", i, rresp, exp_resp));
      if (is_legal(req) && rdata !== model_mem[a])
        note_failure($sformatf("word %0d read %h, expected %h", a, rdata, model_mem[a]));
      if (rlast !== (i == beats - 1)) note_failure($sformatf("rlast %b on beat %0d", rlast, i));
      @(negedge aclk);
      a = next_addr(req, a);
      if (i < beats - 1 && rvalid !== 1'b1)
        note_failure($sformatf("rvalid low after beat %0d", i));
    end
    rready = 1'b0;
    if (rvalid !== 1'b0 || arready !== 1'b1) note_failure("read channel not idle after last beat");
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    burst_req_t req;
    logic [31:0] r;
    int len;
    int start;
    seed = 32'hfe352978;
    aresetn = 1'b0;
    aw_req = '0;
    ar_req = '0;
    awvalid = 1'b0;
    wvalid = 1'b0;
    bready = 1'b0;
    arvalid = 1'b0;
    rready = 1'b0;
    wdata = '0;
    for (int i = 0; i < mem_depth; i++) begin
      model_mem[i] = '0;
      model_flag[i] = 1'b0;
    end
    repeat (2) @(negedge aclk);
    aresetn = 1'b1;
    @(negedge aclk);
    if (awready !== 1'b1 || arready !== 1'b1 || wready !== 1'b0 || bvalid !== 1'b0 ||
        rvalid !== 1'b0 || rlast !== 1'b0) note_failure("handshake levels wrong after reset");
    // empty memory reads as zero with slverr
    read_burst(make_req(0, 15, burst_incr));
    // incr across word 15
    write_burst(make_req(12, 7, burst_incr));
    read_burst(make_req(12, 7, burst_incr));
    write_burst(make_req(5, 3, burst_fixed));
    read_burst(make_req(5, 2, burst_fixed));
    // wraps of 2, 4, 8 and 16 from odd starts
    for (int k = 0; k < 4; k++) begin
      len = (2 << k) - 1;
      start = 5 + 2 * k;
      write_burst(make_req(start, len, burst_wrap));
      read_burst(make_req(start & ~len, len, burst_incr));
    end
    write_burst(make_req(3, 2, burst_reserved));
    read_burst(make_req(3, 2, burst_reserved));
    write_burst(make_req(6, 2, burst_wrap));
    read_burst(make_req(6, 5, burst_wrap));
    read_burst(make_req(0, 15, burst_incr));
    for (int k = 0; k < 40; k++) begin
      r = $random(seed);
      req.addr = r[3:0];
      req.len = r[7:4];
      req.burst = burst_t'(r[9:8]);
      if (r[10]) write_burst(req);
      else read_burst(req);
    end
    $display("bursts: %0d errors: %0d", bursts, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
